/* arith_encoder.f */
logic/arith_enc_pkg.sv
logic/stage_links.sv
logic/pipeline_control.sv
logic/probability_stage.sv
logic/interval_update.sv
logic/renormalizer.sv
logic/arith_encoder.sv
test/arith_encoder_checker.sv
test/arith_encoder_tb.sv

/* logic/arith_enc_pkg.sv */
package arith_enc_pkg;

  // ------------------------------
  // Interval widths
  // ------------------------------
  localparam int RANGE_WIDTH = 16;  // Range and each pre-carry word
  localparam int LOW_WIDTH   = 24;
  localparam int CNT_WIDTH   = 5;   // Signed bit counter

  localparam logic [RANGE_WIDTH-1:0]      RANGE_RESET = 16'd32768;
  localparam logic signed [CNT_WIDTH-1:0] CNT_RESET   = -9;

  // Probability scaling
  localparam int EC_MIN_PROB = 4;
  localparam int PROB_SHIFT  = 6;

  // Words emitted by one renormalization
  typedef enum logic [1:0] {
    EMIT_NONE = 2'd0,
    EMIT_ONE  = 2'd1,
    EMIT_TWO  = 2'd2
  } emit_flag_t;

  // EC_MIN_PROB per symbol above index, index -1 covers the whole alphabet
  function automatic int min_prob_offset(input int nsyms, input int index);
    int above;
    above = nsyms - 1 - index;
    if (above < 0) begin
      above = 0;  // Index past the alphabet
    end
    return EC_MIN_PROB * above;
  endfunction

  // Bits needed to hold the largest offset of a given alphabet width
  function automatic int offset_width(input int symbol_width);
    return symbol_width + $clog2(EC_MIN_PROB) + 1;
  endfunction

endpackage

/* logic/arith_encoder.sv */
`timescale 1ns/1ps

module arith_encoder import arith_enc_pkg::*; #(
  parameter int SYMBOL_WIDTH = 4
) (
  input  logic                    general_clk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  logic [RANGE_WIDTH-1:0]  fl,
  input  logic [RANGE_WIDTH-1:0]  fh,
  input  logic [SYMBOL_WIDTH-1:0] symbol,
  input  logic [SYMBOL_WIDTH:0]   nsyms,
  input  logic                    bool_mode,
  output logic                    out_valid,
  output logic [RANGE_WIDTH-1:0]  range_out,
  output logic [LOW_WIDTH-1:0]    low_out,
  output logic [CNT_WIDTH-1:0]    cnt_out,
  output emit_flag_t              bit_flag,
  output logic [RANGE_WIDTH-1:0]  out_bit_1,
  output logic [RANGE_WIDTH-1:0]  out_bit_2
);

  // Stage enables
  logic en_12;
  logic en_23;
  logic en_final;

  s12_if #(.SYMBOL_WIDTH(SYMBOL_WIDTH)) s12 ();
  s23_if s23 ();

  // ------------------------------
  // Control
  // ------------------------------
  pipeline_control u_control (
    .general_clk (general_clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .en_12       (en_12),
    .en_23       (en_23),
    .en_final    (en_final),
    .out_valid   (out_valid)
  );

  // ------------------------------
  // Pipeline stages
  // ------------------------------
  probability_stage #(
    .SYMBOL_WIDTH (SYMBOL_WIDTH)
  ) u_stage_1 (
    .general_clk (general_clk),
    .en_12       (en_12),
    .fl          (fl),
    .fh          (fh),
    .symbol      (symbol),
    .nsyms       (nsyms),
    .bool_mode   (bool_mode),
    .link        (s12.src)
  );

  interval_update u_stage_2 (
    .general_clk (general_clk),
    .reset       (reset),
    .en_23       (en_23),
    .in_link     (s12.dst),
    .out_link    (s23.src)
  );

  renormalizer u_stage_3 (
    .general_clk (general_clk),
    .reset       (reset),
    .en_final    (en_final),
    .in_link     (s23.dst),
    .range_out   (range_out),
    .low_out     (low_out),
    .cnt_out     (cnt_out),
    .bit_flag    (bit_flag),
    .out_bit_1   (out_bit_1),  // Higher word when two
    .out_bit_2   (out_bit_2)
  );

endmodule

/* logic/interval_update.sv */
`timescale 1ns/1ps

module interval_update import arith_enc_pkg::*; (
  input  logic general_clk,
  input  logic reset,
  input  logic en_23,
  s12_if.dst   in_link,
  s23_if.src   out_link
);

  localparam int TOP_WIDTH  = 8;
  localparam int PROD_WIDTH = TOP_WIDTH + RANGE_WIDTH - PROB_SHIFT;
  localparam int WIDE       = RANGE_WIDTH + 1;

  logic [RANGE_WIDTH-1:0] range_q;
  logic [TOP_WIDTH-1:0]   range_top;
  logic [PROD_WIDTH-1:0]  prod_fl;
  logic [PROD_WIDTH-1:0]  prod_fh;
  logic [WIDE-1:0]        u_val;
  logic [WIDE-1:0]        v_val;
  logic [RANGE_WIDTH-1:0] u_low;
  logic [RANGE_WIDTH-1:0] v_low;
  logic [RANGE_WIDTH-1:0] low_add_next;
  logic [RANGE_WIDTH-1:0] range_raw;
  logic [CNT_WIDTH-1:0]   d_next;

  // ------------------------------
  // Scaled bounds
  // ------------------------------
  assign range_top = range_q[RANGE_WIDTH-1 -: TOP_WIDTH];  // r >> 8
  assign prod_fl   = range_top * in_link.fl_scaled;
  assign prod_fh   = range_top * in_link.fh_scaled;

  assign u_val = WIDE'(prod_fl >> 1) + WIDE'(in_link.offset_u);
  assign v_val = WIDE'(prod_fh >> 1) + WIDE'(in_link.offset_v);
  assign u_low = u_val[RANGE_WIDTH-1:0];
  assign v_low = v_val[RANGE_WIDTH-1:0];

  // Normal, first-symbol or bool update
  always_comb begin
    low_add_next = '0;
    range_raw    = range_q - v_low;  // First symbol and bool zero
    if (in_link.bool_mode) begin
      if (in_link.sym_bit) begin
        low_add_next = range_q - v_low;
        range_raw    = v_low;
      end
    end else if (!in_link.first_sym) begin
      low_add_next = range_q - u_low;
      range_raw    = u_low - v_low;
    end
  end

  // Leading-one search, highest set bit wins
  always_comb begin
    d_next = '0;
    for (int i = 0; i < RANGE_WIDTH; i++) begin
      if (range_raw[i]) begin
        d_next = CNT_WIDTH'(RANGE_WIDTH - 1 - i);
      end
    end
  end

  // ------------------------------
  // Stage 2 register and range loop
  // ------------------------------
  always_ff @(posedge general_clk) begin
    if (reset) begin
      range_q        <= RANGE_RESET;
      out_link.valid <= 1'b0;
    end else begin
      out_link.valid <= in_link.valid;
      if (en_23) begin
        range_q <= range_raw << d_next;  // Holds through bubbles
      end
    end
  end

  always_ff @(posedge general_clk) begin
    if (en_23) begin
      out_link.low_add <= low_add_next;
      out_link.d       <= d_next;
    end
  end

  assign out_link.range = range_q;

  // Stage 1 offsets keep the normal interval non-empty
  assert property (@(posedge general_clk) disable iff (reset)
    (en_23 && in_link.valid && !in_link.bool_mode && !in_link.first_sym)
      |-> (u_val > v_val))
    else $error("Normal symbol with u not above v");

endmodule

/* logic/pipeline_control.sv */
`timescale 1ns/1ps

module pipeline_control (
  input  logic general_clk,
  input  logic reset,
  input  logic in_valid,
  output logic en_12,
  output logic en_23,
  output logic en_final,
  output logic out_valid
);

  localparam int DEPTH = 3;

  // One bit per symbol in flight
  logic [DEPTH-1:0] vld_q;

  // ------------------------------
  // Valid shift register
  // ------------------------------
  always_ff @(posedge general_clk) begin
    if (reset) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[DEPTH-2:0], in_valid};
    end
  end

  // Stage 1 register takes the input beat directly
  assign en_12 = in_valid;

  // Each later stage loads when the one before holds a symbol
  assign en_23    = vld_q[0];
  assign en_final = vld_q[1];

  assign out_valid = vld_q[DEPTH-1];  // Outputs just loaded

endmodule

/* logic/probability_stage.sv */
`timescale 1ns/1ps

module probability_stage import arith_enc_pkg::*; #(
  parameter int SYMBOL_WIDTH = 4
) (
  input  logic                    general_clk,
  input  logic                    en_12,
  input  logic [RANGE_WIDTH-1:0]  fl,
  input  logic [RANGE_WIDTH-1:0]  fh,
  input  logic [SYMBOL_WIDTH-1:0] symbol,
  input  logic [SYMBOL_WIDTH:0]   nsyms,
  input  logic                    bool_mode,
  s12_if.src                      link
);

  localparam int OFFSET_WIDTH = offset_width(SYMBOL_WIDTH);
  localparam int NSYM_ROWS    = 2 ** (SYMBOL_WIDTH + 1);
  localparam int SYM_COLS     = 2 ** SYMBOL_WIDTH;

  // CDF top, marks the first symbol of the alphabet
  localparam logic [RANGE_WIDTH-1:0] CDF_TOP = {1'b1, {(RANGE_WIDTH-1){1'b0}}};

  logic [OFFSET_WIDTH-1:0] u_table [NSYM_ROWS][SYM_COLS];
  logic [OFFSET_WIDTH-1:0] v_table [NSYM_ROWS][SYM_COLS];
  logic [OFFSET_WIDTH-1:0] offset_u_next;
  logic [OFFSET_WIDTH-1:0] offset_v_next;

  // ------------------------------
  // Offset ROM
  // ------------------------------
  for (genvar n = 0; n < NSYM_ROWS; n++) begin : g_row
    for (genvar s = 0; s < SYM_COLS; s++) begin : g_col
      // u uses the symbol below, v the symbol itself
      assign u_table[n][s] = OFFSET_WIDTH'(min_prob_offset(n, s - 1));
      assign v_table[n][s] = OFFSET_WIDTH'(min_prob_offset(n, s));
    end
  end

  assign offset_u_next = u_table[nsyms][symbol];

  // Bool mode always adds a single minimum step to v
  assign offset_v_next = bool_mode ? OFFSET_WIDTH'(EC_MIN_PROB)
                                   : v_table[nsyms][symbol];

  // ------------------------------
  // Stage 1 register
  // ------------------------------
  always_ff @(posedge general_clk) begin
    link.valid <= en_12;  // Strobe, one beat per symbol
  end

  always_ff @(posedge general_clk) begin
    if (en_12) begin
      link.bool_mode <= bool_mode;
      link.sym_bit   <= symbol[0];
      link.first_sym <= (fl == CDF_TOP);
      link.fl_scaled <= fl[RANGE_WIDTH-1:PROB_SHIFT];  // fl >> 6
      link.fh_scaled <= fh[RANGE_WIDTH-1:PROB_SHIFT];
      link.offset_u  <= offset_u_next;
      link.offset_v  <= offset_v_next;
    end
  end

endmodule

/* logic/renormalizer.sv */
`timescale 1ns/1ps

module renormalizer import arith_enc_pkg::*; (
  input  logic                   general_clk,
  input  logic                   reset,
  input  logic                   en_final,
  s23_if.dst                     in_link,
  output logic [RANGE_WIDTH-1:0] range_out,
  output logic [LOW_WIDTH-1:0]   low_out,
  output logic [CNT_WIDTH-1:0]   cnt_out,
  output emit_flag_t             bit_flag,
  output logic [RANGE_WIDTH-1:0] out_bit_1,
  output logic [RANGE_WIDTH-1:0] out_bit_2
);

  localparam int SUM_WIDTH = CNT_WIDTH + 1;  // Room for cnt + d

  logic [LOW_WIDTH-1:0]        low_q;
  logic signed [CNT_WIDTH-1:0] cnt_q;
  logic signed [SUM_WIDTH-1:0] cnt_ext;
  logic signed [SUM_WIDTH-1:0] d_ext;
  logic signed [SUM_WIDTH-1:0] s_sum;
  logic signed [SUM_WIDTH-1:0] c_shift;
  logic [LOW_WIDTH-1:0]        low_sum;
  logic [LOW_WIDTH-1:0]        mask;
  logic [LOW_WIDTH-1:0]        low_rem;
  logic [RANGE_WIDTH-1:0]      word_1;
  logic [RANGE_WIDTH-1:0]      word_2;
  logic signed [CNT_WIDTH-1:0] cnt_next;
  emit_flag_t                  flag_next;

  assign cnt_ext = cnt_q;                      // Sign extends
  assign d_ext   = $signed({1'b0, in_link.d});
  assign s_sum   = cnt_ext + d_ext;
  assign low_sum = low_q + LOW_WIDTH'(in_link.low_add);

  // ------------------------------
  // Emission of pre-carry words
  // ------------------------------
  always_comb begin
    c_shift   = cnt_ext + SUM_WIDTH'(RANGE_WIDTH);
    mask      = (LOW_WIDTH'(1) << c_shift) - 1'b1;
    low_rem   = low_sum;
    word_1    = '0;
    word_2    = '0;
    flag_next = EMIT_NONE;
    cnt_next  = s_sum[CNT_WIDTH-1:0];  // No word, count is s
    if (s_sum >= 0) begin
      word_1    = RANGE_WIDTH'(low_sum >> c_shift);
      low_rem   = low_sum & mask;
      flag_next = EMIT_ONE;
      // Enough bits for a second byte below the first word
      if (s_sum >= 8) begin
        c_shift   = c_shift - 8;
        mask      = mask >> 8;
        word_2    = RANGE_WIDTH'(low_rem >> c_shift);
        low_rem   = low_rem & mask;
        flag_next = EMIT_TWO;
      end
      cnt_next = CNT_WIDTH'(c_shift + d_ext - 24);
    end
  end

  // ------------------------------
  // Output registers and low loop
  // ------------------------------
  always_ff @(posedge general_clk) begin
    if (reset) begin
      low_q     <= '0;
      cnt_q     <= CNT_RESET;
      range_out <= RANGE_RESET;
      bit_flag  <= EMIT_NONE;
    end else if (en_final) begin
      low_q     <= low_rem << in_link.d;  // Keeps 24 bits
      cnt_q     <= cnt_next;
      range_out <= in_link.range;
      bit_flag  <= flag_next;
    end
  end

  always_ff @(posedge general_clk) begin
    if (en_final) begin
      out_bit_1 <= word_1;
      out_bit_2 <= word_2;
    end
  end

  assign low_out = low_q;
  assign cnt_out = cnt_q;

  // Shift found in stage 2 must leave a normalized range at the output
  assert property (@(posedge general_clk) disable iff (reset)
    (en_final && in_link.valid) |=> range_out[RANGE_WIDTH-1])
    else $error("Range not normalized at output");

endmodule

/* logic/stage_links.sv */
`timescale 1ns/1ps

// ------------------------------
// Stage 1 to stage 2
// ------------------------------
interface s12_if import arith_enc_pkg::*; #(
  parameter int SYMBOL_WIDTH = 4
) ();

  localparam int OFFSET_WIDTH = offset_width(SYMBOL_WIDTH);
  localparam int SCALED_WIDTH = RANGE_WIDTH - PROB_SHIFT;

  logic                    valid;
  logic                    bool_mode;
  logic                    sym_bit;    // Symbol bit 0, bool decision
  logic                    first_sym;  // fl at CDF top
  logic [SCALED_WIDTH-1:0] fl_scaled;
  logic [SCALED_WIDTH-1:0] fh_scaled;
  logic [OFFSET_WIDTH-1:0] offset_u;
  logic [OFFSET_WIDTH-1:0] offset_v;  // EC_MIN_PROB in bool mode

  modport src (
    output valid, bool_mode, sym_bit, first_sym,
    output fl_scaled, fh_scaled, offset_u, offset_v
  );

  modport dst (
    input valid, bool_mode, sym_bit, first_sym,
    input fl_scaled, fh_scaled, offset_u, offset_v
  );

endinterface

// ------------------------------
// Stage 2 to stage 3
// ------------------------------
interface s23_if import arith_enc_pkg::*; ();

  logic                   valid;
  logic [RANGE_WIDTH-1:0] low_add;  // Added to low before the shift
  logic [CNT_WIDTH-1:0]   d;        // Renormalization shift
  logic [RANGE_WIDTH-1:0] range;    // Already shifted by d

  modport src (output valid, low_add, d, range);

  modport dst (input valid, low_add, d, range);

endinterface

/* test/arith_encoder_checker.sv */
`timescale 1ns/1ps

module arith_encoder_checker import arith_enc_pkg::*; #(
  parameter int SYMBOL_WIDTH = 4
) (
  input  logic                    general_clk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  logic [RANGE_WIDTH-1:0]  fl,
  input  logic [RANGE_WIDTH-1:0]  fh,
  input  logic [SYMBOL_WIDTH-1:0] symbol,
  input  logic [SYMBOL_WIDTH:0]   nsyms,
  input  logic                    bool_mode,
  input  logic                    expect_valid,  // Table column for out_valid three edges on
  input  logic                    out_valid,
  input  logic [RANGE_WIDTH-1:0]  range_out,
  input  logic [LOW_WIDTH-1:0]    low_out,
  input  logic [CNT_WIDTH-1:0]    cnt_out,
  input  emit_flag_t              bit_flag,
  input  logic [RANGE_WIDTH-1:0]  out_bit_1,
  input  logic [RANGE_WIDTH-1:0]  out_bit_2,
  output int                      value_errors,
  output int                      protocol_errors,
  output int                      pending
);

  int m_range;
  int m_low;
  int m_cnt;
  int cycle;
  int hold_range;  // Last output held through bubbles
  int hold_low;
  bit reset_checked;
  logic [2:0] exp_pipe;
  int q_range[$];
  int q_low[$];
  int q_cnt[$];
  int q_flag[$];
  int q_w1[$];
  int q_w2[$];
  int q_due[$];

  task automatic mismatch(input string what, input int got, input int exp);
    $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    value_errors++;
  endtask

  task automatic compare(input string what, input int got, input int exp);
    if (got != exp) begin
      mismatch(what, got, exp);
    end
  endtask

  // ------------------------------
  // Reference model of one symbol
  // ------------------------------
  task automatic predict(input int f_lo, input int f_hi, input int sym, input int ns,
                         input bit bmode);
    int q_lo, q_hi, u, v, low_add, raw, d, s, c, low_sum, w1, w2, flag;
    q_lo = ((m_range >> 8) * (f_lo >> PROB_SHIFT)) >> 1;
    q_hi = ((m_range >> 8) * (f_hi >> PROB_SHIFT)) >> 1;
    u = (q_lo + min_prob_offset(ns, sym - 1)) & 16'hffff;
    v = bmode ? (q_hi + EC_MIN_PROB) & 16'hffff : (q_hi + min_prob_offset(ns, sym)) & 16'hffff;
    low_add = 0;
    raw = (m_range - v) & 16'hffff;  // First symbol and bool zero
    if (bmode && sym[0]) begin
      low_add = (m_range - v) & 16'hffff;
      raw = v;
    end else if (!bmode && f_lo != 32768) begin
      low_add = (m_range - u) & 16'hffff;
      raw = (u - v) & 16'hffff;
    end
    d = 0;
    for (int i = 0; i < 16; i++) begin
      if (raw[i]) d = 15 - i;
    end
    s = m_cnt + d;
    low_sum = (m_low + low_add) & 24'hffffff;
    w1 = 0;
    w2 = 0;
    flag = 0;
    if (s >= 0) begin
      c = m_cnt + 16;
      w1 = (low_sum >> c) & 16'hffff;
      low_sum = low_sum & ((1 << c) - 1);
      flag = 1;
      if (s >= 8) begin
        c = c - 8;
        w2 = (low_sum >> c) & 16'hffff;
        low_sum = low_sum & ((1 << c) - 1);
        flag = 2;
      end
      m_cnt = c + d - 24;
    end else begin
      m_cnt = s;
    end
    m_low = (low_sum << d) & 24'hffffff;
    m_range = (raw << d) & 16'hffff;
    q_range.push_back(m_range);
    q_low.push_back(m_low);
    q_cnt.push_back(m_cnt & 5'h1f);
    q_flag.push_back(flag);
    q_w1.push_back(w1);
    q_w2.push_back(w2);
    q_due.push_back(cycle + 3);
  endtask

  task automatic drop_front();
    void'(q_range.pop_front());
    void'(q_low.pop_front());
    void'(q_cnt.pop_front());
    void'(q_flag.pop_front());
    void'(q_w1.pop_front());
    void'(q_w2.pop_front());
    void'(q_due.pop_front());
  endtask

  initial begin
    value_errors = 0;
    protocol_errors = 0;
    pending = 0;
  end

  always @(posedge general_clk) begin
    if (reset) begin
      m_range = RANGE_RESET;
      m_low = 0;
      m_cnt = -9;
      cycle = 0;
      hold_range = RANGE_RESET;
      hold_low = 0;
      reset_checked = 0;
      exp_pipe = '0;
      while (q_due.size() > 0) drop_front();
    end else begin
      cycle++;
      if (!reset_checked) begin  // State right after reset
        compare("range_out after reset", range_out, 32768);
        compare("low_out after reset", low_out, 0);
        compare("cnt_out after reset", cnt_out, 5'h17);
        compare("bit_flag after reset", bit_flag, EMIT_NONE);
        compare("out_valid after reset", out_valid, 0);
        reset_checked = 1;
      end
      compare("out_valid against table", out_valid, exp_pipe[2]);
      exp_pipe = {exp_pipe[1:0], expect_valid};

      // ------------------------------
      // Output compare
      // ------------------------------
      if (out_valid) begin
        if (q_due.size() == 0) begin
          $display("ERROR at %0t: out_valid came with no symbol in flight", $time);
          protocol_errors++;
        end else begin
          if (q_due[0] != cycle) begin
            $display("ERROR at %0t: out_valid came at the wrong cycle", $time);
            protocol_errors++;
          end
          compare("range_out", range_out, q_range[0]);
          compare("low_out", low_out, q_low[0]);
          compare("cnt_out", cnt_out, q_cnt[0]);
          compare("bit_flag", bit_flag, q_flag[0]);
          if (q_flag[0] >= 1) compare("out_bit_1", out_bit_1, q_w1[0]);
          if (q_flag[0] == 2) compare("out_bit_2", out_bit_2, q_w2[0]);
          hold_range = q_range[0];
          hold_low = q_low[0];
          drop_front();
        end
      end else begin
        compare("range_out in bubble", range_out, hold_range);
        compare("low_out in bubble", low_out, hold_low);
        if (q_due.size() > 0 && q_due[0] <= cycle) begin
          $display("ERROR at %0t: out_valid missing for a symbol", $time);
          protocol_errors++;
          drop_front();
        end
      end

      if (in_valid) predict(fl, fh, symbol, nsyms, bool_mode);
    end
    pending = q_due.size();
  end

endmodule

/* test/arith_encoder_tb.sv */
`timescale 1ns/1ps

module arith_encoder_tb import arith_enc_pkg::*; ();

  localparam int SYMBOL_WIDTH = 4;
  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 16;
  localparam int TABLE_ROWS   = 24;
  localparam int RANDOM_BEATS = 200;
  localparam int WATCHDOG_NS  = (TABLE_ROWS + RANDOM_BEATS + RESET_CYCLES + 30) * CLK_PERIOD;

  typedef struct packed {
    logic        valid;
    logic [15:0] fl;
    logic [15:0] fh;
    logic [3:0]  symbol;
    logic [4:0]  nsyms;
    logic        bool_mode;
    logic        exp_valid;  // out_valid three edges later
  } row_t;

  // valid, fl, fh, symbol, nsyms, bool_mode, expected out_valid
  row_t stim_table [TABLE_ROWS] = '{
    '{1, 32768, 24000, 0, 4, 0, 1},  // First symbol
    '{1, 24000, 12000, 1, 4, 0, 1},
    '{0, 0, 0, 0, 0, 0, 0},
    '{1, 12000, 5000, 2, 4, 0, 1},
    '{1, 5000, 0, 3, 4, 0, 1},
    '{1, 0, 16384, 0, 2, 1, 1},      // Bool with bit 0 clear
    '{1, 0, 8000, 1, 2, 1, 1},
    '{0, 0, 0, 0, 0, 0, 0},
    '{0, 0, 0, 0, 0, 0, 0},
    '{1, 32768, 30000, 0, 8, 0, 1},
    '{1, 1000, 900, 2, 8, 0, 1},     // Low probability run emits words
    '{1, 700, 680, 3, 8, 0, 1},
    '{1, 700, 680, 3, 8, 0, 1},
    '{0, 0, 0, 0, 0, 0, 0},
    '{1, 0, 100, 1, 2, 1, 1},
    '{1, 0, 100, 1, 2, 1, 1},
    '{1, 1000, 900, 2, 8, 0, 1},
    '{1, 0, 31000, 0, 2, 1, 1},
    '{1, 32768, 32000, 0, 16, 0, 1},
    '{1, 600, 590, 15, 16, 0, 1},
    '{0, 0, 0, 0, 0, 0, 0},
    '{1, 640, 576, 5, 16, 0, 1},
    '{1, 0, 200, 1, 2, 1, 1},
    '{1, 20000, 19000, 7, 16, 0, 1}
  };

  logic                    general_clk;
  logic                    reset;
  logic                    in_valid;
  logic [RANGE_WIDTH-1:0]  fl;
  logic [RANGE_WIDTH-1:0]  fh;
  logic [SYMBOL_WIDTH-1:0] symbol;
  logic [SYMBOL_WIDTH:0]   nsyms;
  logic                    bool_mode;
  logic                    expect_valid;
  logic                    out_valid;
  logic [RANGE_WIDTH-1:0]  range_out;
  logic [LOW_WIDTH-1:0]    low_out;
  logic [CNT_WIDTH-1:0]    cnt_out;
  emit_flag_t              bit_flag;
  logic [RANGE_WIDTH-1:0]  out_bit_1;
  logic [RANGE_WIDTH-1:0]  out_bit_2;
  int                      value_errors;
  int                      protocol_errors;
  int                      pending;
  int                      seed = 32'hafdd_098a;

  arith_encoder #(.SYMBOL_WIDTH(SYMBOL_WIDTH)) uut (.*);

  arith_encoder_checker #(.SYMBOL_WIDTH(SYMBOL_WIDTH)) u_checker (.*);

  always #(CLK_PERIOD / 2) general_clk = ~general_clk;

  task automatic apply_beat(input row_t row);
    @(posedge general_clk);
    #DRIVE_DELAY;
    in_valid     = row.valid;
    fl           = row.fl;
    fh           = row.fh;
    symbol       = row.symbol;
    nsyms        = row.nsyms;
    bool_mode    = row.bool_mode;
    expect_valid = row.exp_valid;
  endtask

  // Random symbol with fl above fh and a bubble about one beat in four
  function automatic row_t random_row();
    row_t row;
    row = '0;
    row.valid = ({$random(seed)} % 4) != 0;
    row.exp_valid = row.valid;
    row.nsyms = 2 + {$random(seed)} % 15;
    row.symbol = {$random(seed)} % row.nsyms;
    row.bool_mode = ({$random(seed)} % 4) == 0;
    if (row.bool_mode || row.symbol == 0) begin
      row.fh = {$random(seed)} % 32768;
      row.fl = row.bool_mode ? 16'd0 : 16'd32768;
    end else begin
      row.fh = {$random(seed)} % 32000;
      row.fl = row.fh + 1 + {$random(seed)} % (32767 - row.fh);
    end
    return row;
  endfunction

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    general_clk  = 1'b0;
    reset        = 1'b1;
    in_valid     = 1'b0;
    fl           = '0;
    fh           = '0;
    symbol       = '0;
    nsyms        = '0;
    bool_mode    = 1'b0;
    expect_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge general_clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    for (int i = 0; i < TABLE_ROWS; i++) begin
      apply_beat(stim_table[i]);
    end
    for (int i = 0; i < RANDOM_BEATS; i++) begin
      apply_beat(random_row());
    end
    apply_beat('0);
    while (pending != 0) @(posedge general_clk);
    repeat (4) @(posedge general_clk);
    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #WATCHDOG_NS;
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule
